/* rtl/xt_periph_pkg.sv */
/*
 * XT peripheral glue shared definitions
 * Bus widths, system-board port groups, EMS constants and the address word
 */
package xt_periph_pkg;

    // XT bus widths
    localparam int ADDR_W = 20;
    localparam int DATA_W = 8;

    // System-board chip selects, one per 32-port group from 000h
    localparam int CS_W        = 5;
    localparam int CS_DMA      = 0;
    localparam int CS_PIC      = 1;
    localparam int CS_PIT      = 2;
    localparam int CS_PPI      = 3;
    localparam int CS_DMA_PAGE = 4;

    // EMS page registers
    localparam int                EMS_PAGES        = 4;
    localparam int                EMS_PAGE_W       = 7;
    localparam logic [15:0]       EMS_PORT_BASE    = 16'h0260;
    localparam logic [DATA_W-1:0] EMS_DISABLE_BYTE = 8'hFF;

    // Upper address nibble of each selectable page frame
    localparam logic [3:0] EMS_FRAME_A = 4'hA;
    localparam logic [3:0] EMS_FRAME_C = 4'hC;
    localparam logic [3:0] EMS_FRAME_D = 4'hD;

    typedef struct packed {
        logic [ADDR_W-17:0] unused;
        logic [15:0]        port;
    } io_view_t;

    // 16 KB window number and offset inside it
    typedef struct packed {
        logic [5:0]  window;
        logic [13:0] offset;
    } mem_view_t;

    typedef union packed {
        io_view_t  io;
        mem_view_t mem;
    } bus_address_t;

endpackage

/* rtl/io_decoder.sv */
/*
 * System-board I/O decoder
 * Drives the active-low chip selects and the EMS register port select
 */
`timescale 1ns/1ps

module io_decoder (
    input  xt_periph_pkg::bus_address_t          address_i,
    input  logic                                 address_enable_n_i,
    input  logic                                 ems_enable_i,
    output logic [xt_periph_pkg::CS_W-1:0]       chip_select_n_o,
    output logic                                 ems_port_sel_o
);

    import xt_periph_pkg::*;

    logic       board_range;
    logic [2:0] port_group;

    // Only ports 000h-0FFh belong to the system board
    assign board_range = ~address_enable_n_i && (address_i.io.port[9:8] == 2'b00);
    assign port_group  = address_i.io.port[7:5];

    always_comb begin
        chip_select_n_o = '1;
        if (board_range) begin
            case (port_group)
                3'd0: begin
                    chip_select_n_o[CS_DMA] = 1'b0;
                end
                3'd1: begin
                    chip_select_n_o[CS_PIC] = 1'b0;
                end
                3'd2: begin
                    chip_select_n_o[CS_PIT] = 1'b0;
                end
                3'd3: begin
                    chip_select_n_o[CS_PPI] = 1'b0;
                end
                3'd4: begin
                    chip_select_n_o[CS_DMA_PAGE] = 1'b0;
                end
                // Groups 0A0h-0FFh have no device here
                default: begin
                    chip_select_n_o = '1;
                end
            endcase
        end
    end

    // EMS registers sit at 260h-263h, full 16-bit compare
    assign ems_port_sel_o = ems_enable_i && ~address_enable_n_i &&
                            (address_i.io.port[15:2] == EMS_PORT_BASE[15:2]);

endmodule

/* rtl/ems_mapper.sv */
/*
 * EMS page mapper
 * Four page registers with enables, register read-back and
 * memory-window hit detection in the selected page frame
 */
`timescale 1ns/1ps

module ems_mapper (
    input  logic                                  clock,
    input  logic                                  reset,
    input  xt_periph_pkg::bus_address_t           address_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]      data_i,
    input  logic                                  io_write_n_i,
    input  logic                                  ems_port_sel_i,
    input  logic [1:0]                            frame_sel_i,
    output logic [xt_periph_pkg::DATA_W-1:0]      ems_read_data_o,
    output logic [xt_periph_pkg::EMS_PAGES-1:0]   window_hit_o
);

    import xt_periph_pkg::*;

    logic [EMS_PAGES-1:0][EMS_PAGE_W-1:0] page_map;
    logic [EMS_PAGES-1:0]                 page_enable;
    logic [1:0]                           reg_sel;
    logic                                 write_strobe;
    logic [3:0]                           frame_nibble;

    assign reg_sel      = address_i.io.port[1:0];
    assign write_strobe = ems_port_sel_i && ~io_write_n_i;

    // FFh unmaps a page, 00h-7Fh maps one, anything else is ignored
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            page_map    <= '0;
            page_enable <= '0;
        end else if (write_strobe) begin
            if (data_i == EMS_DISABLE_BYTE) begin
                page_map[reg_sel]    <= '0;
                page_enable[reg_sel] <= 1'b0;
            end else if (!data_i[DATA_W-1]) begin
                page_map[reg_sel]    <= data_i[EMS_PAGE_W-1:0];
                page_enable[reg_sel] <= 1'b1;
            end
        end
    end

    // Unmapped pages read back as FFh
    assign ems_read_data_o = page_enable[reg_sel] ?
                             {{(DATA_W-EMS_PAGE_W){1'b0}}, page_map[reg_sel]} :
                             EMS_DISABLE_BYTE;

    always_comb begin
        case (frame_sel_i)
            2'd0:    frame_nibble = EMS_FRAME_A;
            2'd1:    frame_nibble = EMS_FRAME_C;
            default: frame_nibble = EMS_FRAME_D;
        endcase
    end

    // Page k owns the k-th 16 KB window of the frame
    always_comb begin
        for (int k = 0; k < EMS_PAGES; k++) begin
            window_hit_o[k] = page_enable[k] &&
                              (address_i.mem.window == {frame_nibble, 2'(k)});
        end
    end

endmodule

/* rtl/peripheral_sync.sv */
/*
 * Clock-crossing glue for the timer clock, keyboard data and keyboard reset
 */
`timescale 1ns/1ps

module peripheral_sync (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                peripheral_clock_i,
    input  logic                                ps2_irq_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]    keycode_i,
    input  logic                                kbd_reset_n_i,
    output logic                                timer_clock_o,
    output logic                                kbd_irq_o,
    output logic [xt_periph_pkg::DATA_W-1:0]    port_a_data_o,
    output logic                                kbd_reset_req_o
);

    import xt_periph_pkg::*;

    logic              timer_toggle;
    logic              timer_meta;
    logic              kbd_irq_stage;
    logic [DATA_W-1:0] keycode_stage;
    logic              kbd_reset_prev;

    // Divide by two in the peripheral clock domain
    always_ff @(posedge peripheral_clock_i or posedge reset) begin
        if (reset) begin
            timer_toggle <= 1'b0;
        end else begin
            timer_toggle <= ~timer_toggle;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            timer_meta    <= 1'b0;
            timer_clock_o <= 1'b0;
        end else begin
            timer_meta    <= timer_toggle;
            timer_clock_o <= timer_meta;
        end
    end

    // Keyboard IRQ and keycode, two stages toward PPI port A
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            kbd_irq_stage <= 1'b0;
            kbd_irq_o     <= 1'b0;
            keycode_stage <= '0;
            port_a_data_o <= '0;
        end else begin
            kbd_irq_stage <= ps2_irq_i;
            kbd_irq_o     <= kbd_irq_stage;
            keycode_stage <= keycode_i;
            port_a_data_o <= keycode_stage;
        end
    end

    // One-cycle request on a rising keyboard reset line
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            kbd_reset_prev  <= 1'b0;
            kbd_reset_req_o <= 1'b0;
        end else begin
            kbd_reset_prev  <= kbd_reset_n_i;
            kbd_reset_req_o <= kbd_reset_n_i && !kbd_reset_prev;
        end
    end

endmodule

/* rtl/bus_readback.sv */
/*
 * CPU read-back multiplexer
 * Picks which source owns the CPU data bus, interrupt acknowledge first
 */
`timescale 1ns/1ps

module bus_readback (
    input  logic [xt_periph_pkg::CS_W-1:0]      chip_select_n_i,
    input  logic                                ems_port_sel_i,
    input  logic                                io_read_n_i,
    input  logic                                interrupt_acknowledge_n_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]    pic_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]    pit_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]    ppi_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]    ems_data_i,
    output logic [xt_periph_pkg::DATA_W-1:0]    data_o,
    output logic                                data_valid_o
);

    import xt_periph_pkg::*;

    always_comb begin
        data_valid_o = 1'b1;
        // Vector byte during an interrupt acknowledge cycle
        if (!interrupt_acknowledge_n_i) begin
            data_o = pic_data_i;
        end else if (!chip_select_n_i[CS_PIC] && !io_read_n_i) begin
            data_o = pic_data_i;
        end else if (!chip_select_n_i[CS_PIT] && !io_read_n_i) begin
            data_o = pit_data_i;
        end else if (!chip_select_n_i[CS_PPI] && !io_read_n_i) begin
            data_o = ppi_data_i;
        end else if (ems_port_sel_i && !io_read_n_i) begin
            data_o = ems_data_i;
        end else begin
            // Nobody on the bus
            data_o       = '0;
            data_valid_o = 1'b0;
        end
    end

endmodule

/* rtl/xt_periph_top.sv */
/*
 * XT peripheral glue top level
 * Wires the I/O decoder, EMS mapper, clock-crossing glue and read-back mux
 */
`timescale 1ns/1ps

module xt_periph_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  peripheral_clock_i,
    input  logic [xt_periph_pkg::ADDR_W-1:0]      address_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]      data_i,
    input  logic                                  io_read_n_i,
    input  logic                                  io_write_n_i,
    input  logic                                  address_enable_n_i,
    input  logic                                  interrupt_acknowledge_n_i,
    input  logic                                  ems_enable_i,
    input  logic [1:0]                            frame_sel_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]      pic_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]      pit_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]      ppi_data_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]      port_b_i,
    input  logic                                  ps2_irq_i,
    input  logic [xt_periph_pkg::DATA_W-1:0]      keycode_i,
    output logic [xt_periph_pkg::CS_W-1:0]        chip_select_n_o,
    output logic [xt_periph_pkg::DATA_W-1:0]      data_o,
    output logic                                  data_valid_o,
    output logic [xt_periph_pkg::EMS_PAGES-1:0]   window_hit_o,
    output logic                                  timer_clock_o,
    output logic                                  kbd_irq_o,
    output logic [xt_periph_pkg::DATA_W-1:0]      port_a_data_o,
    output logic                                  kbd_reset_req_o
);

    import xt_periph_pkg::*;

    logic              ems_port_sel;
    logic [DATA_W-1:0] ems_read_data;

    io_decoder io_decoder_inst (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .ems_enable_i       (ems_enable_i),
        .chip_select_n_o    (chip_select_n_o),
        .ems_port_sel_o     (ems_port_sel)
    );

    ems_mapper ems_mapper_inst (
        .clock           (clock),
        .reset           (reset),
        .address_i       (address_i),
        .data_i          (data_i),
        .io_write_n_i    (io_write_n_i),
        .ems_port_sel_i  (ems_port_sel),
        .frame_sel_i     (frame_sel_i),
        .ems_read_data_o (ems_read_data),
        .window_hit_o    (window_hit_o)
    );

    // Port B bit 6 is the keyboard clock enable, low holds the keyboard in reset
    peripheral_sync peripheral_sync_inst (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .ps2_irq_i          (ps2_irq_i),
        .keycode_i          (keycode_i),
        .kbd_reset_n_i      (port_b_i[6]),
        .timer_clock_o      (timer_clock_o),
        .kbd_irq_o          (kbd_irq_o),
        .port_a_data_o      (port_a_data_o),
        .kbd_reset_req_o    (kbd_reset_req_o)
    );

    bus_readback bus_readback_inst (
        .chip_select_n_i           (chip_select_n_o),
        .ems_port_sel_i            (ems_port_sel),
        .io_read_n_i               (io_read_n_i),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
        .pic_data_i                (pic_data_i),
        .pit_data_i                (pit_data_i),
        .ppi_data_i                (ppi_data_i),
        .ems_data_i                (ems_read_data),
        .data_o                    (data_o),
        .data_valid_o              (data_valid_o)
    );

endmodule

/* testbench/xt_periph_checker.sv */
/*
 * Bound assertions on the XT peripheral glue top level
 */
`timescale 1ns/1ps

module xt_periph_checker (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [xt_periph_pkg::CS_W-1:0]        chip_select_n_i,
    input  logic                                  kbd_reset_req_i,
    input  logic [xt_periph_pkg::EMS_PAGES-1:0]   window_hit_i,
    input  logic                                  ems_enable_i
);

    logic ems_seen;
    int   failure_count = 0;

    // Remembers whether EMS was ever enabled since the last reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ems_seen <= 1'b0;
        end else if (ems_enable_i) begin
            ems_seen <= 1'b1;
        end
    end

    chip_select_onehot: assert property (@(posedge clock) disable iff (reset)
        $countones(~chip_select_n_i) <= 1)
        else begin
            $error("more than one chip select active");
            failure_count++;
        end

    kbd_reset_single_cycle: assert property (@(posedge clock) disable iff (reset)
        kbd_reset_req_i |=> !kbd_reset_req_i)
        else begin
            $error("keyboard reset request longer than one cycle");
            failure_count++;
        end

    no_hit_without_ems: assert property (@(posedge clock) disable iff (reset)
        !ems_seen |-> (window_hit_i == '0))
        else begin
            $error("window hit while EMS never enabled");
            failure_count++;
        end

endmodule

/* testbench/xt_periph_tb.sv */
/*
 * Testbench for the XT peripheral glue
 * Directed tests for decode, EMS pages and windows, read-back and clock crossing
 */
`timescale 1ns/1ps

module xt_periph_tb;

    import xt_periph_pkg::*;

    localparam int SAMPLE_DELAY = 25;

    logic clock;
    logic reset;
    logic peripheral_clock_i;
    logic [ADDR_W-1:0] address_i;
    logic [DATA_W-1:0] data_i;
    logic io_read_n_i;
    logic io_write_n_i;
    logic address_enable_n_i;
    logic interrupt_acknowledge_n_i;
    logic ems_enable_i;
    logic [1:0] frame_sel_i;
    logic [DATA_W-1:0] pic_data_i;
    logic [DATA_W-1:0] pit_data_i;
    logic [DATA_W-1:0] ppi_data_i;
    logic [DATA_W-1:0] port_b_i;
    logic ps2_irq_i;
    logic [DATA_W-1:0] keycode_i;
    logic [CS_W-1:0] chip_select_n_o;
    logic [DATA_W-1:0] data_o;
    logic data_valid_o;
    logic [EMS_PAGES-1:0] window_hit_o;
    logic timer_clock_o;
    logic kbd_irq_o;
    logic [DATA_W-1:0] port_a_data_o;
    logic kbd_reset_req_o;

    logic [31:0] rand_state = 32'h5743;
    int error_count = 0;
    int failed_tests = 0;
    int test_count = 0;
    int assertion_failures;

    // Expected EMS page contents
    logic [6:0] page_value [4];
    logic       page_on [4];

    xt_periph_top xt_periph_top_inst (.*);

    bind xt_periph_top xt_periph_checker xt_periph_checker_inst (
        .clock           (clock),
        .reset           (reset),
        .chip_select_n_i (chip_select_n_o),
        .kbd_reset_req_i (kbd_reset_req_o),
        .window_hit_i    (window_hit_o),
        .ems_enable_i    (ems_enable_i)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Offset keeps peripheral edges away from the system clock edges
    initial begin
        peripheral_clock_i = 1'b0;
        #20;
        forever #350 peripheral_clock_i = ~peripheral_clock_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string test_name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                 test_name, what, expected, actual);
        error_count++;
    endtask

    task automatic finish_test(input string test_name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: passed", test_name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", test_name, error_count - errors_before);
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int k = 0; k < 4; k++) begin
            page_value[k] = '0;
            page_on[k]    = 1'b0;
        end
    endtask

    task automatic bus_idle();
        @(negedge clock);
        address_enable_n_i        = 1'b1;
        io_read_n_i               = 1'b1;
        io_write_n_i              = 1'b1;
        interrupt_acknowledge_n_i = 1'b1;
    endtask

    // Register write, then read it back in the following cycle
    task automatic ems_write(input string test_name, input logic [1:0] reg_index,
                             input logic [7:0] value);
        logic [7:0] expected;
        @(negedge clock);
        address_i          = 20'h00260 | reg_index;
        data_i             = value;
        address_enable_n_i = 1'b0;
        io_read_n_i        = 1'b1;
        io_write_n_i       = 1'b0;
        @(negedge clock);
        io_write_n_i = 1'b1;
        io_read_n_i  = 1'b0;
        if (value == 8'hFF) begin
            page_on[reg_index]    = 1'b0;
            page_value[reg_index] = '0;
        end else if (value < 8'h80) begin
            page_on[reg_index]    = 1'b1;
            page_value[reg_index] = value[6:0];
        end
        expected = page_on[reg_index] ? {1'b0, page_value[reg_index]} : 8'hFF;
        #SAMPLE_DELAY;
        if (data_o !== expected) begin
            report_mismatch(test_name, "read-back", expected, data_o);
        end
    endtask

    task automatic test_decode();
        int errors_before;
        logic [4:0] expected;
        errors_before = error_count;
        for (int i = 0; i < 48; i++) begin
            rand_state = xorshift32(rand_state);
            @(negedge clock);
            address_i          = rand_state[19:0];
            address_enable_n_i = (rand_state[31:30] == 2'b11);
            if (rand_state[29]) begin
                address_i[9:8] = 2'b00;
            end
            expected = '1;
            if (!address_enable_n_i && address_i[9:8] == 2'b00 && address_i[7:5] < 3'd5) begin
                expected[address_i[7:5]] = 1'b0;
            end
            #SAMPLE_DELAY;
            if (chip_select_n_o !== expected) begin
                report_mismatch("decode", "chip selects", expected, chip_select_n_o);
            end
        end
        finish_test("decode", errors_before);
    endtask

    task automatic test_ems_writes();
        int errors_before;
        logic [7:0] value;
        errors_before = error_count;
        @(negedge clock);
        ems_enable_i = 1'b1;
        for (int i = 0; i < 24; i++) begin
            rand_state = xorshift32(rand_state);
            case (rand_state[9:8])
                2'd0: value = 8'hFF;
                2'd1: value = {1'b0, rand_state[6:0]};
                2'd2: value = {1'b1, rand_state[6:0]};
                default: value = {1'b0, rand_state[14:8]};
            endcase
            ems_write("ems_writes", rand_state[17:16], value);
        end
        finish_test("ems_writes", errors_before);
    endtask

    // Memory sweep over every frame and page slot, plus one address outside
    task automatic sweep_windows(input string test_name);
        logic [3:0] nibble;
        logic [3:0] expected;
        for (int f = 0; f < 4; f++) begin
            nibble = (f == 0) ? 4'hA : ((f == 1) ? 4'hC : 4'hD);
            for (int k = 0; k < 5; k++) begin
                rand_state = xorshift32(rand_state);
                @(negedge clock);
                frame_sel_i        = f[1:0];
                address_enable_n_i = 1'b1;
                address_i = {(k == 4) ? 4'h8 : nibble, k[1:0], rand_state[13:0]};
                for (int j = 0; j < 4; j++) begin
                    expected[j] = page_on[j] && (address_i[19:14] == {nibble, j[1:0]});
                end
                #SAMPLE_DELAY;
                if (window_hit_o !== expected) begin
                    report_mismatch(test_name, "window hits", expected, window_hit_o);
                end
            end
        end
    endtask

    task automatic test_ems_windows();
        int errors_before;
        errors_before = error_count;
        apply_reset();
        ems_enable_i = 1'b0;
        // Register write while EMS is off must not map a page
        @(negedge clock);
        address_i          = 20'h00260;
        data_i             = 8'h00;
        address_enable_n_i = 1'b0;
        io_read_n_i        = 1'b1;
        io_write_n_i       = 1'b0;
        bus_idle();
        sweep_windows("ems_windows");
        @(negedge clock);
        ems_enable_i = 1'b1;
        ems_write("ems_windows", 2'd0, 8'h11);
        ems_write("ems_windows", 2'd1, 8'h05);
        ems_write("ems_windows", 2'd2, 8'hFF);
        ems_write("ems_windows", 2'd3, 8'h7F);
        ems_write("ems_windows", 2'd2, 8'h90);
        bus_idle();
        sweep_windows("ems_windows");
        finish_test("ems_windows", errors_before);
    endtask

    task automatic probe_readback(input string what, input logic [19:0] address,
                                  input logic read_n, input logic ack_n,
                                  input logic [7:0] expected_data, input logic expected_valid);
        @(negedge clock);
        address_i                 = address;
        address_enable_n_i        = 1'b0;
        io_write_n_i              = 1'b1;
        io_read_n_i               = read_n;
        interrupt_acknowledge_n_i = ack_n;
        #SAMPLE_DELAY;
        if (data_o !== expected_data) begin
            report_mismatch("readback", what, expected_data, data_o);
        end
        if (data_valid_o !== expected_valid) begin
            report_mismatch("readback", {what, " valid"}, expected_valid, data_valid_o);
        end
    endtask

    task automatic test_readback();
        int errors_before;
        logic [7:0] ems_expected;
        errors_before = error_count;
        @(negedge clock);
        pic_data_i   = 8'h21;
        pit_data_i   = 8'h42;
        ppi_data_i   = 8'h63;
        ems_expected = page_on[0] ? {1'b0, page_value[0]} : 8'hFF;
        probe_readback("acknowledge", 20'h003F8, 1'b1, 1'b0, 8'h21, 1'b1);
        probe_readback("pic", 20'h00020, 1'b0, 1'b1, 8'h21, 1'b1);
        probe_readback("pit", 20'h00041, 1'b0, 1'b1, 8'h42, 1'b1);
        probe_readback("ppi", 20'h00061, 1'b0, 1'b1, 8'h63, 1'b1);
        probe_readback("ems", 20'h00260, 1'b0, 1'b1, ems_expected, 1'b1);
        probe_readback("ack over pit", 20'h00040, 1'b0, 1'b0, 8'h21, 1'b1);
        probe_readback("pit no read", 20'h00040, 1'b1, 1'b1, 8'h00, 1'b0);
        probe_readback("dma", 20'h00000, 1'b0, 1'b1, 8'h00, 1'b0);
        bus_idle();
        finish_test("readback", errors_before);
    endtask

    task automatic test_keyboard();
        int errors_before;
        int pulses;
        logic [8:0] history [$];
        logic [8:0] expected;
        errors_before = error_count;
        pulses = 0;
        for (int i = 0; i < 20; i++) begin
            rand_state = xorshift32(rand_state);
            @(negedge clock);
            {ps2_irq_i, keycode_i} = rand_state[8:0];
            history.push_back(rand_state[8:0]);
            #SAMPLE_DELAY;
            if (history.size() == 3) begin
                expected = history.pop_front();
                if ({kbd_irq_o, port_a_data_o} !== expected) begin
                    report_mismatch("keyboard", "irq and port A", expected,
                                    {kbd_irq_o, port_a_data_o});
                end
            end
        end
        // Low reset line first, then one rising edge held high
        rand_state = xorshift32(rand_state);
        @(negedge clock);
        port_b_i = rand_state[7:0] & 8'hBF;
        repeat (3) @(negedge clock);
        port_b_i = rand_state[15:8] | 8'h40;
        for (int i = 0; i < 8; i++) begin
            #SAMPLE_DELAY;
            if (kbd_reset_req_o) begin
                pulses++;
            end
            @(negedge clock);
        end
        if (pulses == 0) begin
            $display("keyboard: reset request did not appear within 8 cycles");
            error_count++;
        end else if (pulses != 1) begin
            report_mismatch("keyboard", "reset request cycles", 1, pulses);
        end
        finish_test("keyboard", errors_before);
    endtask

    task automatic test_timer_clock();
        int errors_before;
        int toggles;
        int rises;
        logic last_timer;
        logic last_periph;
        errors_before = error_count;
        toggles = 0;
        rises   = 0;
        @(negedge clock);
        #SAMPLE_DELAY;
        last_timer  = timer_clock_o;
        last_periph = peripheral_clock_i;
        for (int i = 0; i < 140; i++) begin
            @(negedge clock);
            #SAMPLE_DELAY;
            if (timer_clock_o != last_timer) begin
                toggles++;
            end
            if (peripheral_clock_i && !last_periph) begin
                rises++;
            end
            last_timer  = timer_clock_o;
            last_periph = peripheral_clock_i;
        end
        if (rises < 10) begin
            $display("timer_clock: too few peripheral clock edges in the window");
            error_count++;
        end
        if (toggles > rises + 1 || toggles + 1 < rises) begin
            report_mismatch("timer_clock", "toggle count", rises, toggles);
        end
        finish_test("timer_clock", errors_before);
    endtask

    initial begin
        reset                     = 1'b1;
        address_i                 = '0;
        data_i                    = '0;
        io_read_n_i               = 1'b1;
        io_write_n_i              = 1'b1;
        address_enable_n_i        = 1'b1;
        interrupt_acknowledge_n_i = 1'b1;
        ems_enable_i              = 1'b0;
        frame_sel_i               = 2'd0;
        pic_data_i                = '0;
        pit_data_i                = '0;
        ppi_data_i                = '0;
        port_b_i                  = '0;
        ps2_irq_i                 = 1'b0;
        keycode_i                 = '0;
        apply_reset();
        test_decode();
        test_ems_writes();
        test_ems_windows();
        test_readback();
        test_keyboard();
        test_timer_clock();
        assertion_failures = xt_periph_top_inst.xt_periph_checker_inst.failure_count;
        $display("tests run: %0d, tests failed: %0d, errors: %0d, assertion failures: %0d",
                 test_count, failed_tests, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* all.f */
rtl/xt_periph_pkg.sv
rtl/io_decoder.sv
rtl/ems_mapper.sv
rtl/peripheral_sync.sv
rtl/bus_readback.sv
rtl/xt_periph_top.sv
testbench/xt_periph_checker.sv
testbench/xt_periph_tb.sv

/* Bender.yml */
package:
  name: xt_periph

sources:
  - rtl/xt_periph_pkg.sv
  - rtl/io_decoder.sv
  - rtl/ems_mapper.sv
  - rtl/peripheral_sync.sv
  - rtl/bus_readback.sv
  - rtl/xt_periph_top.sv
  - target: test
    files:
      - testbench/xt_periph_checker.sv
      - testbench/xt_periph_tb.sv
